//--- include/bepipe_params.svh
`ifndef BEPIPE_PARAMS_SVH
`define BEPIPE_PARAMS_SVH

// datapath word
`define BP_XLEN 32

// register file address, r0 means no write
`define BP_REG_ADDR_W 5

// lanes that feed results back into ex
`define BP_PIPES 2

// forwarding stages per lane, m1 m2 wb
`define BP_FWD_STAGES 3

// stall/clear controlled stages, ex m1 m2
`define BP_CTRL_STAGES 3

`endif

//--- design/bepipe_pkg.sv
`default_nettype none

`include "bepipe_params.svh"

package bepipe_pkg;

	typedef logic [`BP_XLEN-1:0] word_t;

	typedef logic [`BP_REG_ADDR_W-1:0] reg_addr_t; // 0 = no write back

	// one-hot, [0] held [1] m1 [2] m2 [3] wb
	typedef logic [3:0] fwd_src_t;

	// [0] ex [1] m1 [2] m2
	typedef logic [`BP_CTRL_STAGES-1:0] stage_vec_t;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SLT  = 4'd7,
		ALU_LINK = 4'd8 // pc + 4
	} alu_op_t;

endpackage

`default_nettype wire

//--- design/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

`include "bepipe_params.svh"

module operand_forward (
	input  bepipe_pkg::word_t    old_data_i,
	input  bepipe_pkg::fwd_src_t sel_i,
	input  logic                 pipe_i,
	input  bepipe_pkg::word_t [`BP_PIPES-1:0][`BP_FWD_STAGES-1:0] src_i,
	output bepipe_pkg::word_t    data_o
);

	bepipe_pkg::word_t [`BP_FWD_STAGES-1:0] lane; // results of the selected lane

	assign lane = src_i[pipe_i];

	// sel bit s+1 picks stage s of the lane
	// walked from wb down so the lowest set bit wins
	always_comb begin
		data_o = old_data_i;
		for (int s = `BP_FWD_STAGES - 1; s >= 0; s--) begin
			if (sel_i[s+1]) begin
				data_o = lane[s];
			end
		end
		if (sel_i[0]) begin
			data_o = old_data_i; // held value overrides everything
		end
	end

endmodule

`default_nettype wire

//--- design/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "bepipe_params.svh"

module exec_alu (
	input  bepipe_pkg::alu_op_t op_i,
	input  bepipe_pkg::word_t   a_i,
	input  bepipe_pkg::word_t   b_i,
	input  bepipe_pkg::word_t   pc_i,
	output bepipe_pkg::word_t   result_o
);

	logic [$clog2(`BP_XLEN)-1:0] shamt; // low bits of b only
	logic                        lt;    // signed a < b

	assign shamt = b_i[$clog2(`BP_XLEN)-1:0];
	assign lt    = $signed(a_i) < $signed(b_i);

	always_comb begin
		case (op_i)
			bepipe_pkg::ALU_ADD: begin
				result_o = a_i + b_i;
			end
			bepipe_pkg::ALU_SUB: begin
				result_o = a_i - b_i;
			end
			bepipe_pkg::ALU_AND:  result_o = a_i & b_i;
			bepipe_pkg::ALU_OR:   result_o = a_i | b_i;
			bepipe_pkg::ALU_XOR:  result_o = a_i ^ b_i;
			bepipe_pkg::ALU_SLL:  result_o = a_i << shamt;
			bepipe_pkg::ALU_SRL:  result_o = a_i >> shamt; // logical
			bepipe_pkg::ALU_SLT: begin
				result_o = bepipe_pkg::word_t'(lt);
			end
			// return address for jal style ops
			bepipe_pkg::ALU_LINK: begin
				result_o = pc_i + bepipe_pkg::word_t'(4);
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/ex_issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "bepipe_params.svh"

module ex_issue_stage (
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   issue_i,
	input  bepipe_pkg::alu_op_t    op_i,
	input  bepipe_pkg::reg_addr_t  rd_i,
	input  bepipe_pkg::word_t      pc_i,
	input  bepipe_pkg::word_t      opnd0_i,
	input  bepipe_pkg::word_t      opnd1_i,
	input  bepipe_pkg::fwd_src_t   fwd_sel0_i,
	input  bepipe_pkg::fwd_src_t   fwd_sel1_i,
	input  logic                   fwd_pipe0_i,
	input  logic                   fwd_pipe1_i,
	input  bepipe_pkg::word_t [`BP_PIPES-1:0][`BP_FWD_STAGES-1:0] fwd_src_i,
	input  bepipe_pkg::stage_vec_t stall_vec_i,

	output bepipe_pkg::alu_op_t    ex_op_o,
	output bepipe_pkg::reg_addr_t  ex_rd_o,
	output bepipe_pkg::word_t      ex_pc_o,
	output bepipe_pkg::word_t      ex_a_o,
	output bepipe_pkg::word_t      ex_b_o
);

	bepipe_pkg::alu_op_t   ex_op_q;
	bepipe_pkg::reg_addr_t ex_rd_q;
	bepipe_pkg::word_t     ex_pc_q;

	// per operand state, index 0 is a, 1 is b
	bepipe_pkg::word_t    opnd_q   [2]; // held value
	bepipe_pkg::fwd_src_t sel_q    [2];
	logic                 pipe_q   [2];
	bepipe_pkg::word_t    opnd_fwd [2]; // after forwarding

	bepipe_pkg::word_t    opnd_in  [2];
	bepipe_pkg::fwd_src_t sel_in   [2];
	logic                 pipe_in  [2];

	assign opnd_in[0] = opnd0_i;
	assign opnd_in[1] = opnd1_i;
	assign sel_in[0]  = fwd_sel0_i;
	assign sel_in[1]  = fwd_sel1_i;
	assign pipe_in[0] = fwd_pipe0_i;
	assign pipe_in[1] = fwd_pipe1_i;

	// producer moves one stage on unless its own stage is stalled too,
	// once it leaves wb the captured value is the only copy left
	function automatic bepipe_pkg::fwd_src_t step_sel(
		input bepipe_pkg::fwd_src_t   sel,
		input bepipe_pkg::stage_vec_t stall
	);
		bepipe_pkg::fwd_src_t nxt;
		nxt = sel;
		if (sel[3]) begin
			nxt = 4'b0001;
		end else if (sel[2] && !stall[2]) begin
			nxt = 4'b1000;
		end else if (sel[1] && !stall[1]) begin
			nxt = 4'b0100;
		end
		return nxt;
	endfunction

	for (genvar k = 0; k < 2; k++) begin : g_opnd
		operand_forward i_operand_forward (
			.old_data_i(opnd_q[k]),
			.sel_i     (sel_q[k]),
			.pipe_i    (pipe_q[k]),
			.src_i     (fwd_src_i),
			.data_o    (opnd_fwd[k])
		);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_op_q <= bepipe_pkg::ALU_ADD;
			ex_rd_q <= '0;
			ex_pc_q <= '0;
			for (int k = 0; k < 2; k++) begin
				opnd_q[k] <= '0;
				sel_q[k]  <= 4'b0001;
				pipe_q[k] <= 1'b0;
			end
		end else if (!stall_vec_i[0]) begin
			if (issue_i) begin
				ex_op_q <= op_i;
				ex_rd_q <= rd_i;
				ex_pc_q <= pc_i;
				for (int k = 0; k < 2; k++) begin
					opnd_q[k] <= opnd_in[k];
					sel_q[k]  <= sel_in[k];
					pipe_q[k] <= pipe_in[k];
				end
			end else begin
				// bubble, zero operands so its add result is 0 too
				ex_op_q <= bepipe_pkg::ALU_ADD;
				ex_rd_q <= '0;
				ex_pc_q <= '0;
				for (int k = 0; k < 2; k++) begin
					opnd_q[k] <= '0;
					sel_q[k]  <= 4'b0001;
					pipe_q[k] <= 1'b0;
				end
			end
		end else begin
			for (int k = 0; k < 2; k++) begin
				opnd_q[k] <= opnd_fwd[k]; // snapshot before the source moves on
				sel_q[k]  <= step_sel(sel_q[k], stall_vec_i);
			end
		end
	end

	assign ex_op_o = ex_op_q;
	assign ex_rd_o = ex_rd_q;
	assign ex_pc_o = ex_pc_q;
	assign ex_a_o  = opnd_fwd[0];
	assign ex_b_o  = opnd_fwd[1];

endmodule

`default_nettype wire

//--- design/mem_wb_stages.sv
`timescale 1ns/1ps
`default_nettype none

`include "bepipe_params.svh"

module mem_wb_stages (
	input  logic                   clk,
	input  logic                   rst_n,

	input  bepipe_pkg::stage_vec_t stall_vec_i,
	input  bepipe_pkg::stage_vec_t clr_vec_i,

	// from ex
	input  bepipe_pkg::reg_addr_t  ex_rd_i,
	input  bepipe_pkg::word_t      ex_result_i,

	output bepipe_pkg::reg_addr_t  reg_w_addr_o,
	output bepipe_pkg::word_t      reg_w_data_o,
	output bepipe_pkg::word_t [`BP_FWD_STAGES-1:0] fwd_data_o
);

	// stage s: 0 m1, 1 m2, 2 wb
	bepipe_pkg::reg_addr_t rd_q   [`BP_FWD_STAGES];
	bepipe_pkg::word_t     res_q  [`BP_FWD_STAGES];

	// what each stage would load
	bepipe_pkg::reg_addr_t rd_in  [`BP_FWD_STAGES];
	bepipe_pkg::word_t     res_in [`BP_FWD_STAGES];

	logic [`BP_FWD_STAGES-2:0] hold;   // m1 or m2 keeps its contents
	logic [`BP_FWD_STAGES-1:0] bubble; // stage takes an empty slot

	assign hold = stall_vec_i[`BP_CTRL_STAGES-1:1];

	// upstream stalled or flushed, nothing valid arrives
	assign bubble = clr_vec_i | stall_vec_i;

	always_comb begin
		rd_in[0]  = ex_rd_i;
		res_in[0] = ex_result_i;
		for (int s = 1; s < `BP_FWD_STAGES; s++) begin
			rd_in[s]  = rd_q[s-1];
			res_in[s] = res_q[s-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < `BP_FWD_STAGES; s++) begin
				rd_q[s]  <= '0;
				res_q[s] <= '0;
			end
		end else begin
			for (int s = 0; s < `BP_FWD_STAGES - 1; s++) begin
				if (hold[s]) begin
					rd_q[s]  <= rd_q[s];
					res_q[s] <= res_q[s];
				end else if (bubble[s]) begin
					rd_q[s]  <= '0;
					res_q[s] <= '0;
				end else begin
					rd_q[s]  <= rd_in[s];
					res_q[s] <= res_in[s];
				end
			end
			// wb has no stall of its own, it always moves
			if (bubble[`BP_FWD_STAGES-1]) begin
				rd_q[`BP_FWD_STAGES-1]  <= '0;
				res_q[`BP_FWD_STAGES-1] <= '0;
			end else begin
				rd_q[`BP_FWD_STAGES-1]  <= rd_in[`BP_FWD_STAGES-1];
				res_q[`BP_FWD_STAGES-1] <= res_in[`BP_FWD_STAGES-1];
			end
		end
	end

	// register file write port
	assign reg_w_addr_o = rd_q[`BP_FWD_STAGES-1];
	assign reg_w_data_o = res_q[`BP_FWD_STAGES-1];

	// results offered to both lanes' ex stages
	always_comb begin
		for (int s = 0; s < `BP_FWD_STAGES; s++) begin
			fwd_data_o[s] = res_q[s];
		end
	end

endmodule

`default_nettype wire

//--- design/backend_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bepipe_params.svh"

module backend_pipe_top (
	input  logic                   clk,
	input  logic                   rst_n,

	// issue side
	input  logic                   issue_i,
	input  bepipe_pkg::alu_op_t    op_i,
	input  bepipe_pkg::reg_addr_t  rd_i,
	input  bepipe_pkg::word_t      pc_i,
	input  bepipe_pkg::word_t      opnd0_i,
	input  bepipe_pkg::word_t      opnd1_i,
	input  bepipe_pkg::fwd_src_t   fwd_sel0_i,
	input  bepipe_pkg::fwd_src_t   fwd_sel1_i,
	input  logic                   fwd_pipe0_i,
	input  logic                   fwd_pipe1_i,

	// results of both lanes, [lane][m1/m2/wb]
	input  bepipe_pkg::word_t [`BP_PIPES-1:0][`BP_FWD_STAGES-1:0] fwd_src_i,

	input  bepipe_pkg::stage_vec_t stall_vec_i,
	input  bepipe_pkg::stage_vec_t clr_vec_i,

	output bepipe_pkg::reg_addr_t  reg_w_addr_o,
	output bepipe_pkg::word_t      reg_w_data_o,
	output bepipe_pkg::word_t [`BP_FWD_STAGES-1:0] fwd_data_o
);

	bepipe_pkg::alu_op_t   ex_op;
	bepipe_pkg::reg_addr_t ex_rd;
	bepipe_pkg::word_t     ex_pc;
	bepipe_pkg::word_t     ex_a;
	bepipe_pkg::word_t     ex_b;
	bepipe_pkg::word_t     ex_result;

	ex_issue_stage i_ex_issue_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue_i    (issue_i),
		.op_i       (op_i),
		.rd_i       (rd_i),
		.pc_i       (pc_i),
		.opnd0_i    (opnd0_i),
		.opnd1_i    (opnd1_i),
		.fwd_sel0_i (fwd_sel0_i),
		.fwd_sel1_i (fwd_sel1_i),
		.fwd_pipe0_i(fwd_pipe0_i),
		.fwd_pipe1_i(fwd_pipe1_i),
		.fwd_src_i  (fwd_src_i),
		.stall_vec_i(stall_vec_i),
		.ex_op_o    (ex_op),
		.ex_rd_o    (ex_rd),
		.ex_pc_o    (ex_pc),
		.ex_a_o     (ex_a),
		.ex_b_o     (ex_b)
	);

	exec_alu i_exec_alu (
		.op_i    (ex_op),
		.a_i     (ex_a),
		.b_i     (ex_b),
		.pc_i    (ex_pc),
		.result_o(ex_result)
	);

	mem_wb_stages i_mem_wb_stages (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall_vec_i (stall_vec_i),
		.clr_vec_i   (clr_vec_i),
		.ex_rd_i     (ex_rd),
		.ex_result_i (ex_result),
		.reg_w_addr_o(reg_w_addr_o),
		.reg_w_data_o(reg_w_data_o),
		.fwd_data_o  (fwd_data_o)
	);

endmodule

`default_nettype wire

//--- verification/tb_backend_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "bepipe_params.svh"

module tb_backend_pipe;

	localparam int N_IDLE    = 4;
	localparam int N_PLAIN   = 200;
	localparam int N_FWD     = 200;
	localparam int N_EXSTALL = 300;
	localparam int N_ALL     = 400;
	localparam int N_DRAIN   = 6;
	localparam int LAT_LIMIT = 10;
	localparam int WB        = `BP_FWD_STAGES - 1;
	localparam int TOTAL_CYCLES = 3 + N_IDLE + 9 + N_PLAIN + N_FWD + N_EXSTALL + N_ALL
		+ 2 * N_DRAIN + LAT_LIMIT + 2;

	logic                   clk;
	logic                   rst_n;
	logic                   issue;
	bepipe_pkg::alu_op_t    op;
	bepipe_pkg::reg_addr_t  rd;
	bepipe_pkg::word_t      pc;
	bepipe_pkg::word_t      opnd0;
	bepipe_pkg::word_t      opnd1;
	bepipe_pkg::fwd_src_t   sel0;
	bepipe_pkg::fwd_src_t   sel1;
	logic                   pipe0;
	logic                   pipe1;
	bepipe_pkg::word_t [`BP_PIPES-1:0][`BP_FWD_STAGES-1:0] fwd_src;
	bepipe_pkg::stage_vec_t stall_vec;
	bepipe_pkg::stage_vec_t clr_vec;
	bepipe_pkg::reg_addr_t  reg_w_addr;
	bepipe_pkg::word_t      reg_w_data;
	bepipe_pkg::word_t [`BP_FWD_STAGES-1:0] fwd_data;

	// model of ex and of m1/m2/wb
	bepipe_pkg::alu_op_t   m_op;
	bepipe_pkg::reg_addr_t m_ex_rd;
	bepipe_pkg::word_t     m_pc;
	bepipe_pkg::word_t     m_opnd [2];
	bepipe_pkg::fwd_src_t  m_sel  [2];
	logic                  m_pipe [2];
	bepipe_pkg::reg_addr_t m_rd   [`BP_FWD_STAGES];
	bepipe_pkg::word_t     m_res  [`BP_FWD_STAGES];

	logic [31:0] lfsr;
	int          errors;
	int          checks;

	backend_pipe_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_i     (issue),
		.op_i        (op),
		.rd_i        (rd),
		.pc_i        (pc),
		.opnd0_i     (opnd0),
		.opnd1_i     (opnd1),
		.fwd_sel0_i  (sel0),
		.fwd_sel1_i  (sel1),
		.fwd_pipe0_i (pipe0),
		.fwd_pipe1_i (pipe1),
		.fwd_src_i   (fwd_src),
		.stall_vec_i (stall_vec),
		.clr_vec_i   (clr_vec),
		.reg_w_addr_o(reg_w_addr),
		.reg_w_data_o(reg_w_data),
		.fwd_data_o  (fwd_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(TOTAL_CYCLES * 10 + 500);
		$display("timeout: the test sequence did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	// galois lfsr, one step per bit
	function automatic logic draw_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [31:0] draw(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) v = {v[30:0], draw_bit()};
		return v;
	endfunction

	function automatic logic one_in_four();
		logic [31:0] r;
		r = draw(2);
		return r[1:0] == 2'b11;
	endfunction

	function automatic bepipe_pkg::word_t alu_model(input bepipe_pkg::alu_op_t o,
		input bepipe_pkg::word_t a, input bepipe_pkg::word_t b, input bepipe_pkg::word_t p);
		case (o)
			bepipe_pkg::ALU_ADD:  return a + b;
			bepipe_pkg::ALU_SUB:  return a - b;
			bepipe_pkg::ALU_AND:  return a & b;
			bepipe_pkg::ALU_OR:   return a | b;
			bepipe_pkg::ALU_XOR:  return a ^ b;
			bepipe_pkg::ALU_SLL:  return a << b[4:0];
			bepipe_pkg::ALU_SRL:  return a >> b[4:0];
			bepipe_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			bepipe_pkg::ALU_LINK: return p + 32'd4;
			default:              return '0;
		endcase
	endfunction

	function automatic bepipe_pkg::word_t fwd_model(input bepipe_pkg::word_t held,
		input bepipe_pkg::fwd_src_t sel, input logic pipe);
		if (sel[0]) return held;
		if (sel[1]) return fwd_src[pipe][0];
		if (sel[2]) return fwd_src[pipe][1];
		if (sel[3]) return fwd_src[pipe][2];
		return held;
	endfunction

	// producer advances unless its own stage is stalled
	function automatic bepipe_pkg::fwd_src_t sel_step(input bepipe_pkg::fwd_src_t sel,
		input bepipe_pkg::stage_vec_t st);
		case (sel)
			4'b0010: return st[1] ? sel : 4'b0100;
			4'b0100: return st[2] ? sel : 4'b1000;
			4'b1000: return 4'b0001;
			default: return sel;
		endcase
	endfunction

	task automatic model_reset();
		m_op    = bepipe_pkg::ALU_ADD;
		m_ex_rd = '0;
		m_pc    = '0;
		for (int k = 0; k < 2; k++) begin
			m_opnd[k] = '0;
			m_sel[k]  = 4'b0001;
			m_pipe[k] = 1'b0;
		end
		for (int s = 0; s < `BP_FWD_STAGES; s++) begin
			m_rd[s]  = '0;
			m_res[s] = '0;
		end
	endtask

	// one rising edge, with the inputs that were stable across it
	task automatic model_step();
		bepipe_pkg::word_t fwd [2];
		bepipe_pkg::word_t ex_res;
		fwd[0] = fwd_model(m_opnd[0], m_sel[0], m_pipe[0]);
		fwd[1] = fwd_model(m_opnd[1], m_sel[1], m_pipe[1]);
		ex_res = alu_model(m_op, fwd[0], fwd[1], m_pc);
		m_rd[2]  = (clr_vec[2] || stall_vec[2]) ? '0 : m_rd[1];
		m_res[2] = (clr_vec[2] || stall_vec[2]) ? '0 : m_res[1];
		if (!stall_vec[2]) begin
			m_rd[1]  = (clr_vec[1] || stall_vec[1]) ? '0 : m_rd[0];
			m_res[1] = (clr_vec[1] || stall_vec[1]) ? '0 : m_res[0];
		end
		if (!stall_vec[1]) begin
			m_rd[0]  = (clr_vec[0] || stall_vec[0]) ? '0 : m_ex_rd;
			m_res[0] = (clr_vec[0] || stall_vec[0]) ? '0 : ex_res;
		end
		if (stall_vec[0]) begin
			for (int k = 0; k < 2; k++) begin
				m_opnd[k] = fwd[k];
				m_sel[k]  = sel_step(m_sel[k], stall_vec);
			end
		end else if (issue) begin
			m_op      = op;
			m_ex_rd   = rd;
			m_pc      = pc;
			m_opnd[0] = opnd0;
			m_opnd[1] = opnd1;
			m_sel[0]  = sel0;
			m_sel[1]  = sel1;
			m_pipe[0] = pipe0;
			m_pipe[1] = pipe1;
		end else begin
			model_reset_ex();
		end
	endtask

	task automatic model_reset_ex();
		m_op    = bepipe_pkg::ALU_ADD; // bubble
		m_ex_rd = '0;
		m_pc    = '0;
		for (int k = 0; k < 2; k++) begin
			m_opnd[k] = '0;
			m_sel[k]  = 4'b0001;
			m_pipe[k] = 1'b0;
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_outputs();
		check_word("reg_w_addr", 32'(reg_w_addr), 32'(m_rd[WB]));
		check_word("reg_w_data", reg_w_data, m_res[WB]);
		for (int s = 0; s < `BP_FWD_STAGES; s++) begin
			check_word($sformatf("fwd_data[%0d]", s), fwd_data[s], m_res[s]);
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#1; // registers settled, inputs not yet changed
		model_step();
		check_outputs();
	endtask

	task automatic drive_idle();
		issue     = 1'b0;
		op        = bepipe_pkg::ALU_ADD;
		rd        = '0;
		pc        = '0;
		opnd0     = '0;
		opnd1     = '0;
		sel0      = 4'b0001;
		sel1      = 4'b0001;
		pipe0     = 1'b0;
		pipe1     = 1'b0;
		fwd_src   = '0;
		stall_vec = '0;
		clr_vec   = '0;
	endtask

	// force_op < 0 draws a random op
	task automatic drive_random(input bit rand_sel, input bit rand_stall,
		input bit rand_clr, input int force_op);
		logic [31:0] r;
		r = draw(2);
		issue = (force_op >= 0) || (r[1:0] != 2'b00);
		r = draw(4);
		op = (force_op >= 0) ? bepipe_pkg::alu_op_t'(4'(force_op))
			: bepipe_pkg::alu_op_t'(4'(r % 9));
		rd    = bepipe_pkg::reg_addr_t'(draw(`BP_REG_ADDR_W));
		pc    = draw(`BP_XLEN);
		opnd0 = draw(`BP_XLEN);
		opnd1 = draw(`BP_XLEN);
		sel0  = rand_sel ? bepipe_pkg::fwd_src_t'(4'b0001 << draw(2)) : 4'b0001;
		sel1  = rand_sel ? bepipe_pkg::fwd_src_t'(4'b0001 << draw(2)) : 4'b0001;
		pipe0 = draw_bit();
		pipe1 = draw_bit();
		for (int p = 0; p < `BP_PIPES; p++) begin
			for (int s = 0; s < `BP_FWD_STAGES; s++) fwd_src[p][s] = draw(`BP_XLEN);
		end
		for (int i = 0; i < `BP_CTRL_STAGES; i++) begin
			stall_vec[i] = rand_stall ? one_in_four() : 1'b0;
			clr_vec[i]   = rand_clr ? one_in_four() : 1'b0;
		end
	endtask

	// directed link op, write-back expected 3 edges after issue
	task automatic check_latency();
		int                    waited;
		bepipe_pkg::reg_addr_t lat_rd;
		bepipe_pkg::word_t     lat_pc;
		drive_random(1'b0, 1'b0, 1'b0, int'(bepipe_pkg::ALU_LINK));
		rd     = rd | 5'd1; // r0 would not show up
		lat_rd = rd;
		lat_pc = pc;
		tick();
		drive_idle();
		waited = 0;
		while (waited < LAT_LIMIT && reg_w_addr != lat_rd) begin
			tick();
			waited++;
		end
		checks++;
		assert (waited == 3) else begin
			errors++;
			$display("CHECK FAILED @%0t: link write-back after %0d edges, expected 3",
				$time, waited);
		end
		check_word("link result", reg_w_data, lat_pc + 32'd4);
	endtask

	initial begin
		lfsr   = 32'hb600;
		errors = 0;
		checks = 0;
		rst_n  = 1'b0;
		drive_idle();
		model_reset();
		repeat (3) @(posedge clk);
		#1 rst_n = 1'b1;
		check_outputs();
		repeat (N_IDLE) tick();
		for (int o = 0; o < 9; o++) begin
			drive_random(1'b0, 1'b0, 1'b0, o); // every op once
			tick();
		end
		repeat (N_PLAIN) begin
			drive_random(1'b0, 1'b0, 1'b0, -1);
			tick();
		end
		repeat (N_FWD) begin
			drive_random(1'b1, 1'b0, 1'b0, -1);
			tick();
		end
		repeat (N_EXSTALL) begin
			drive_random(1'b1, 1'b1, 1'b0, -1);
			tick();
		end
		repeat (N_ALL) begin
			drive_random(1'b1, 1'b1, 1'b1, -1);
			tick();
		end
		drive_idle();
		repeat (N_DRAIN) tick();
		check_latency();
		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
design/bepipe_pkg.sv
design/operand_forward.sv
design/exec_alu.sv
design/ex_issue_stage.sv
design/mem_wb_stages.sv
design/backend_pipe_top.sv
verification/tb_backend_pipe.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --assert -j 0
TOP   = tb_backend_pipe
FLIST = flist.f

OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(shell grep -v '^+' $(FLIST))
HDRS    = $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
